//--- sram_ctl.f
src/ctl_bus_pkg.sv
src/ra_port_pkg.sv
src/ctl_cmd_route.sv
src/ctl_read_seq.sv
src/sram_ctl.sv
tests/sram_ctl_checker.sv
tests/sram_ctl_monitor.sv
tests/sram_ctl_tb.sv

//--- src/ctl_bus_pkg.sv
// host bus package: command widths, control address map and cfg0 layout
`default_nettype none

package ctl_bus_pkg;

  // host command address and data words
  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;

  // byte selects, bit 0 gates array writes
  typedef logic [3:0] bus_sel_t;

  // region field lives in address bits 15:12
  localparam bus_addr_t ADDR_MASK   = 32'h0000_F000;

  // array configuration port region
  localparam bus_addr_t CFG_REGION  = 32'h0000_E000;

  // bist control and status region
  localparam bus_addr_t BIST_REGION = 32'h0000_F000;

  // cfg0 offset inside the control space, region bits ignored
  localparam bus_addr_t CFG0_OFFSET = 32'h0000_0000;

  // cfg0 layout
  //   31:3  reserved, stored but unused
  //    2:0  read wait cycles after the command cycle
  localparam bus_data_t CFG0_RESET  = 32'h0000_0001;

  // width of the read wait field at the bottom of cfg0
  localparam int WAIT_W = 3;

  // wait count loaded into the read sequencer
  typedef logic [WAIT_W-1:0] wait_t;

endpackage

`default_nettype wire

//--- src/ctl_cmd_route.sv
// command router: decodes host commands, holds cfg0 and drives the array ports
`timescale 1ns/1ps
`default_nettype none

module ctl_cmd_route (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           ctl_cmd_val,
  input  wire                           ra0_cmd_val,
  input  wire ctl_bus_pkg::bus_addr_t   cmd_adr,
  input  wire                           cmd_we,
  input  wire ctl_bus_pkg::bus_sel_t    cmd_sel,
  input  wire ctl_bus_pkg::bus_data_t   cmd_dat,
  input  wire                           seq_busy,
  output logic                          rd_start,
  output ra_port_pkg::seq_state_e       rd_src,
  output ctl_bus_pkg::bus_data_t        cfg0_q,
  output ctl_bus_pkg::wait_t            cfg0_wait,
  output logic                          ra0_cfg_wr,
  output ra_port_pkg::ra_data_t         ra0_cfg_wdat,
  output ra_port_pkg::ra_data_t         ra0_bist_ctl,
  output logic                          ra0_r0_enb,
  output ra_port_pkg::row_addr_t        ra0_r0_adr,
  output logic                          ra0_r1_enb,
  output ra_port_pkg::row_addr_t        ra0_r1_adr,
  output logic                          ra0_w0_enb,
  output ra_port_pkg::row_addr_t        ra0_w0_adr,
  output ra_port_pkg::ra_data_t         ra0_w0_dat
);

  logic                     ctl_acc;
  logic                     ra_acc;
  logic                     adr_bist;
  logic                     adr_cfg;
  logic                     special;
  logic                     cfg0_hit;
  ctl_bus_pkg::bus_addr_t   region;
  ra_port_pkg::rd_type_e    rd_type;
  ra_port_pkg::row_addr_t   row_lo;
  ra_port_pkg::row_addr_t   row_hi;

  // strobes are dropped while a read is still in flight
  assign ctl_acc = ctl_cmd_val & ~seq_busy;
  assign ra_acc  = ra0_cmd_val & ~seq_busy;

  // region decode on address bits 15:12
  assign region   = cmd_adr & ctl_bus_pkg::ADDR_MASK;
  assign adr_bist = region == (ctl_bus_pkg::BIST_REGION & ctl_bus_pkg::ADDR_MASK);
  assign adr_cfg  = region == (ctl_bus_pkg::CFG_REGION & ctl_bus_pkg::ADDR_MASK);
  assign special  = adr_bist | adr_cfg;

  // cfg0 sits at the offset with the region bits masked off
  assign cfg0_hit = (cmd_adr & ~ctl_bus_pkg::ADDR_MASK) == ctl_bus_pkg::CFG0_OFFSET;

  always_ff @(posedge clk) begin
    if (rst) begin
      cfg0_q <= ctl_bus_pkg::CFG0_RESET;
    end else if (ctl_acc & cmd_we & cfg0_hit) begin
      cfg0_q <= cmd_dat;
    end
  end

  // read wait field for the sequencer
  assign cfg0_wait = cfg0_q[ctl_bus_pkg::WAIT_W-1:0];

  // read type and the two row fields of the address
  assign rd_type = ra_port_pkg::rd_type_e'(
      cmd_adr[ra_port_pkg::RD_TYPE_LSB +: ra_port_pkg::RD_TYPE_W]);
  assign row_lo  = cmd_adr[ra_port_pkg::R0_ROW_LSB +: ra_port_pkg::ROW_W];
  assign row_hi  = cmd_adr[ra_port_pkg::R1_ROW_LSB +: ra_port_pkg::ROW_W];

  // special region writes, bist ctl is zero when idle
  assign ra0_bist_ctl = (ra_acc & cmd_we & adr_bist) ? cmd_dat : '0;
  assign ra0_cfg_wr   = ra_acc & cmd_we & adr_cfg;
  assign ra0_cfg_wdat = cmd_dat;

  // plain write, byte select 0 gates the port
  assign ra0_w0_enb = ra_acc & cmd_we & ~special & cmd_sel[0];
  assign ra0_w0_adr = row_lo;
  assign ra0_w0_dat = cmd_dat;

  // plain reads enable only the ports whose data comes back
  // r0 for r0, lo and hi; r1 for r1, lo and hi
  assign ra0_r0_enb = ra_acc & ~cmd_we & ~special & (rd_type != ra_port_pkg::RD_R1);
  assign ra0_r1_enb = ra_acc & ~cmd_we & ~special & (rd_type != ra_port_pkg::RD_R0);
  assign ra0_r0_adr = row_lo;
  // single r1 read takes its row from the low field
  assign ra0_r1_adr = (rd_type == ra_port_pkg::RD_R1) ? row_lo : row_hi;

  // any accepted read starts the sequencer
  assign rd_start = (ctl_acc | ra_acc) & ~cmd_we;

  // read target for the sequencer
  always_comb begin
    rd_src = ra_port_pkg::S_IDLE;
    if (adr_bist) begin
      rd_src = ra_port_pkg::S_BIST;
    end else if (adr_cfg) begin
      rd_src = ra_port_pkg::S_ACFG;
    end else if (ctl_cmd_val) begin
      rd_src = ra_port_pkg::S_CFG0;
    end else begin
      case (rd_type)
        ra_port_pkg::RD_R0: rd_src = ra_port_pkg::S_R0;
        ra_port_pkg::RD_R1: rd_src = ra_port_pkg::S_R1;
        ra_port_pkg::RD_LO: rd_src = ra_port_pkg::S_LO;
        default:            rd_src = ra_port_pkg::S_HI;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/ctl_read_seq.sv
// read sequencer: waits the programmed cycles, then acks one read word
`timescale 1ns/1ps
`default_nettype none

module ctl_read_seq (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           rd_start,
  input  wire ra_port_pkg::seq_state_e  rd_src,
  input  wire ctl_bus_pkg::wait_t       cfg0_wait,
  input  wire ctl_bus_pkg::bus_data_t   cfg0_q,
  input  wire ra_port_pkg::ra_data_t    ra0_r0_dat,
  input  wire ra_port_pkg::ra_data_t    ra0_r1_dat,
  input  wire ra_port_pkg::ra_data_t    ra0_bist_status,
  input  wire ra_port_pkg::ra_data_t    ra0_cfg_rdat,
  output logic                          seq_busy,
  output logic                          rd_ack,
  output ctl_bus_pkg::bus_data_t        rd_dat
);

  ra_port_pkg::seq_state_e  state_q;
  ra_port_pkg::seq_state_e  state_d;
  ctl_bus_pkg::wait_t       wait_q;
  ctl_bus_pkg::wait_t       wait_d;
  logic                     wait_done;

  // one read in flight at a time
  assign seq_busy = state_q != ra_port_pkg::S_IDLE;

  // counter has run out, data can be returned this cycle
  assign wait_done = wait_q == '0;

  // ack in the target state once the count reaches zero
  assign rd_ack = seq_busy & wait_done;

  // state register
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ra_port_pkg::S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // wait down-counter
  always_ff @(posedge clk) begin
    if (rst) begin
      wait_q <= '0;
    end else begin
      wait_q <= wait_d;
    end
  end

  // next state
  // idle jumps straight to the target named by the router
  // every target state behaves the same, only the data select differs
  always_comb begin
    state_d = state_q;
    case (state_q)
      ra_port_pkg::S_IDLE: begin
        if (rd_start) begin
          state_d = rd_src;
        end
      end
      default: begin
        // ack cycle closes the read
        if (wait_done) begin
          state_d = ra_port_pkg::S_IDLE;
        end
      end
    endcase
  end

  // next count
  // load the wait field with the command, then count down to zero
  always_comb begin
    wait_d = wait_q;
    if (!seq_busy) begin
      if (rd_start) begin
        wait_d = cfg0_wait;
      end
    end else if (!wait_done) begin
      wait_d = wait_q - 1'b1;
    end
  end

  // read data select by target state
  // lo and hi pack the r1 half above the r0 half
  // array ports are held by the array, so the select is just a mux
  always_comb begin
    case (state_q)
      ra_port_pkg::S_R0: begin
        rd_dat = ra0_r0_dat;
      end
      ra_port_pkg::S_R1: begin
        rd_dat = ra0_r1_dat;
      end
      ra_port_pkg::S_LO: begin
        rd_dat = {ra0_r1_dat[ra_port_pkg::HALF_W-1:0],
                  ra0_r0_dat[ra_port_pkg::HALF_W-1:0]};
      end
      ra_port_pkg::S_HI: begin
        rd_dat = {ra0_r1_dat[2*ra_port_pkg::HALF_W-1:ra_port_pkg::HALF_W],
                  ra0_r0_dat[2*ra_port_pkg::HALF_W-1:ra_port_pkg::HALF_W]};
      end
      ra_port_pkg::S_CFG0: begin
        rd_dat = cfg0_q;
      end
      ra_port_pkg::S_BIST: begin
        rd_dat = ra0_bist_status;
      end
      ra_port_pkg::S_ACFG: begin
        rd_dat = ra0_cfg_rdat;
      end
      default: begin
        // idle, nothing to return
        rd_dat = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- src/ra_port_pkg.sv
// register array port package: port widths, row fields, read types and sequencer states
`default_nettype none

package ra_port_pkg;

  // row address width of every array port
  localparam int ROW_W = 5;

  typedef logic [ROW_W-1:0] row_addr_t;

  // one array port word
  typedef logic [31:0] ra_data_t;

  // half word, used by the paired lo/hi reads
  localparam int HALF_W = 16;

  // row fields inside the command address
  // r0 and w0 row sits at the bottom, r1 row above it
  localparam int R0_ROW_LSB = 0;
  localparam int R1_ROW_LSB = 6;

  // read type field in address bits 15:14
  localparam int RD_TYPE_LSB = 14;
  localparam int RD_TYPE_W   = 2;

  // which ports a plain array read uses
  typedef enum logic [RD_TYPE_W-1:0] {
    RD_R0 = 2'd0,
    RD_R1 = 2'd1,
    RD_LO = 2'd2,
    RD_HI = 2'd3
  } rd_type_e;

  // read sequencer states, one per read target
  typedef enum logic [2:0] {
    S_IDLE, S_CFG0, S_BIST, S_ACFG, S_R0, S_R1, S_LO, S_HI
  } seq_state_e;

endpackage

`default_nettype wire

//--- src/sram_ctl.sv
// register file test chip controller: host command routing plus read sequencing
`timescale 1ns/1ps
`default_nettype none

module sram_ctl (
  input  wire                           clk,
  input  wire                           rst,

  // host command side
  input  wire                           ctl_cmd_val,
  input  wire                           ra0_cmd_val,
  input  wire ctl_bus_pkg::bus_addr_t   cmd_adr,
  input  wire                           cmd_we,
  input  wire ctl_bus_pkg::bus_sel_t    cmd_sel,
  input  wire ctl_bus_pkg::bus_data_t   cmd_dat,
  output wire                           rd_ack,
  output wire ctl_bus_pkg::bus_data_t   rd_dat,

  // array side
  output wire                           ra0_cfg_wr,
  input  wire ra_port_pkg::ra_data_t    ra0_cfg_rdat,
  output wire ra_port_pkg::ra_data_t    ra0_cfg_wdat,
  output wire ra_port_pkg::ra_data_t    ra0_bist_ctl,
  input  wire ra_port_pkg::ra_data_t    ra0_bist_status,
  output wire                           ra0_r0_enb,
  output wire ra_port_pkg::row_addr_t   ra0_r0_adr,
  input  wire ra_port_pkg::ra_data_t    ra0_r0_dat,
  output wire                           ra0_r1_enb,
  output wire ra_port_pkg::row_addr_t   ra0_r1_adr,
  input  wire ra_port_pkg::ra_data_t    ra0_r1_dat,
  output wire                           ra0_w0_enb,
  output wire ra_port_pkg::row_addr_t   ra0_w0_adr,
  output wire ra_port_pkg::ra_data_t    ra0_w0_dat
);

  // router to sequencer
  wire                          rd_start;
  wire ra_port_pkg::seq_state_e rd_src;
  wire ctl_bus_pkg::bus_data_t  cfg0_q;
  wire ctl_bus_pkg::wait_t      cfg0_wait;
  // sequencer back to router
  wire                          seq_busy;

  // decode, cfg0 and array port drive
  ctl_cmd_route u_route (
    .clk          (clk),
    .rst          (rst),
    .ctl_cmd_val  (ctl_cmd_val),
    .ra0_cmd_val  (ra0_cmd_val),
    .cmd_adr      (cmd_adr),
    .cmd_we       (cmd_we),
    .cmd_sel      (cmd_sel),
    .cmd_dat      (cmd_dat),
    .seq_busy     (seq_busy),
    .rd_start     (rd_start),
    .rd_src       (rd_src),
    .cfg0_q       (cfg0_q),
    .cfg0_wait    (cfg0_wait),
    .ra0_cfg_wr   (ra0_cfg_wr),
    .ra0_cfg_wdat (ra0_cfg_wdat),
    .ra0_bist_ctl (ra0_bist_ctl),
    .ra0_r0_enb   (ra0_r0_enb),
    .ra0_r0_adr   (ra0_r0_adr),
    .ra0_r1_enb   (ra0_r1_enb),
    .ra0_r1_adr   (ra0_r1_adr),
    .ra0_w0_enb   (ra0_w0_enb),
    .ra0_w0_adr   (ra0_w0_adr),
    .ra0_w0_dat   (ra0_w0_dat)
  );

  // wait, ack and read data return
  ctl_read_seq u_seq (
    .clk             (clk),
    .rst             (rst),
    .rd_start        (rd_start),
    .rd_src          (rd_src),
    .cfg0_wait       (cfg0_wait),
    .cfg0_q          (cfg0_q),
    .ra0_r0_dat      (ra0_r0_dat),
    .ra0_r1_dat      (ra0_r1_dat),
    .ra0_bist_status (ra0_bist_status),
    .ra0_cfg_rdat    (ra0_cfg_rdat),
    .seq_busy        (seq_busy),
    .rd_ack          (rd_ack),
    .rd_dat          (rd_dat)
  );

endmodule

`default_nettype wire

//--- tests/sram_ctl_checker.sv
// protocol checker: concurrent assertions on ack, strobes and array enables, bound to the top
`timescale 1ns/1ps
`default_nettype none

module sram_ctl_checker (
  input wire clk,
  input wire rst,
  input wire ctl_cmd_val,
  input wire ra0_cmd_val,
  input wire cmd_we,
  input wire rd_ack,
  input wire ra0_w0_enb,
  input wire ra0_r0_enb,
  input wire ra0_r1_enb
);

  // number of failed assertions
  int fail_count = 0;

  // ack is a single-cycle pulse
  a_ack_pulse: assert property (@(posedge clk) disable iff (rst) rd_ack |=> !rd_ack)
    else begin
      $error("rd_ack held high for two cycles");
      fail_count++;
    end

  // host drives at most one strobe per cycle
  a_one_strobe: assert property (@(posedge clk) disable iff (rst) !(ctl_cmd_val && ra0_cmd_val))
    else begin
      $error("both command strobes high together");
      fail_count++;
    end

  // array write port only opens on a write
  a_w0_is_write: assert property (@(posedge clk) disable iff (rst) ra0_w0_enb |-> cmd_we)
    else begin
      $error("w0 enable without cmd_we");
      fail_count++;
    end

  // read ports stay shut on any write
  a_rd_not_write: assert property (@(posedge clk) disable iff (rst)
      (ra0_r0_enb || ra0_r1_enb) |-> !cmd_we)
    else begin
      $error("read enable high during a write");
      fail_count++;
    end

endmodule

bind sram_ctl sram_ctl_checker u_checker (
  .clk         (clk),
  .rst         (rst),
  .ctl_cmd_val (ctl_cmd_val),
  .ra0_cmd_val (ra0_cmd_val),
  .cmd_we      (cmd_we),
  .rd_ack      (rd_ack),
  .ra0_w0_enb  (ra0_w0_enb),
  .ra0_r0_enb  (ra0_r0_enb),
  .ra0_r1_enb  (ra0_r1_enb)
);

`default_nettype wire

//--- tests/sram_ctl_monitor.sv
// DUT monitor: checks array drive, ack latency and read data against the command rules
`timescale 1ns/1ps
`default_nettype none

module sram_ctl_monitor (
  input  wire           clk,
  input  wire           rst,
  input  wire           ctl_cmd_val,
  input  wire           ra0_cmd_val,
  input  wire [31:0]    cmd_adr,
  input  wire           cmd_we,
  input  wire [3:0]     cmd_sel,
  input  wire [31:0]    cmd_dat,
  input  wire           rd_ack,
  input  wire [31:0]    rd_dat,
  input  wire           ra0_cfg_wr,
  input  wire [31:0]    ra0_cfg_wdat,
  input  wire [31:0]    ra0_bist_ctl,
  input  wire           ra0_r0_enb,
  input  wire [4:0]     ra0_r0_adr,
  input  wire           ra0_r1_enb,
  input  wire [4:0]     ra0_r1_adr,
  input  wire           ra0_w0_enb,
  input  wire [4:0]     ra0_w0_adr,
  input  wire [31:0]    ra0_w0_dat,
  input  wire [127:0]   test_name,
  input  wire [31:0]    exp_dat,
  input  wire [31:0]    exp_lat,
  output logic          rd_done,
  output int            err_count,
  output int            chk_count
);

  // longest legal latency is 8, one more means the ack is lost
  localparam int ACK_LIMIT = 9;

  int          n_err = 0;
  int          n_chk = 0;
  logic        pend;
  int          lat;
  logic        in_bist;
  logic        in_acfg;
  logic        plain;
  logic        e_r0;
  logic        e_r1;
  logic        e_w0;
  logic        e_cfg_wr;
  logic [31:0] e_bist;
  logic [1:0]  rtype;
  logic [4:0]  e_r1_row;

  assign err_count = n_err;
  assign chk_count = n_chk;

  // region in bits 15:12, read type in bits 15:14
  assign in_bist  = cmd_adr[15:12] == 4'hF;
  assign in_acfg  = cmd_adr[15:12] == 4'hE;
  assign plain    = ra0_cmd_val & ~in_bist & ~in_acfg;
  assign rtype    = cmd_adr[15:14];

  // r0 is used by r0, lo and hi reads, r1 by r1, lo and hi reads
  assign e_r0     = plain & ~cmd_we & (rtype != 2'd1);
  assign e_r1     = plain & ~cmd_we & (rtype != 2'd0);
  assign e_w0     = plain & cmd_we & cmd_sel[0];
  assign e_cfg_wr = ra0_cmd_val & cmd_we & in_acfg;
  assign e_bist   = (ra0_cmd_val & cmd_we & in_bist) ? cmd_dat : 32'h0;
  // a single r1 read takes the low row field
  assign e_r1_row = (rtype == 2'd1) ? cmd_adr[4:0] : cmd_adr[10:6];

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    n_chk++;
    if (exp !== act) begin
      n_err++;
      $display("FAIL %0s %0s: expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  always @(posedge clk) begin : watch
    int lat_now;
    if (rst) begin
      pend    <= 1'b0;
      lat     <= 0;
      rd_done <= 1'b0;
    end else begin
      rd_done <= 1'b0;
      if (ctl_cmd_val | ra0_cmd_val) begin
        // strobe cycle, array drive follows the command directly
        check_val("r0 enable", e_r0, ra0_r0_enb);
        check_val("r1 enable", e_r1, ra0_r1_enb);
        check_val("w0 enable", e_w0, ra0_w0_enb);
        check_val("cfg write", e_cfg_wr, ra0_cfg_wr);
        check_val("bist ctl", e_bist, ra0_bist_ctl);
        if (e_r0) begin
          check_val("r0 row", cmd_adr[4:0], ra0_r0_adr);
        end
        if (e_r1) begin
          check_val("r1 row", e_r1_row, ra0_r1_adr);
        end
        if (e_w0) begin
          check_val("w0 row", cmd_adr[4:0], ra0_w0_adr);
          check_val("w0 data", cmd_dat, ra0_w0_dat);
        end
        if (e_cfg_wr) begin
          check_val("cfg data", cmd_dat, ra0_cfg_wdat);
        end
        if (!cmd_we) begin
          pend <= 1'b1;
          lat  <= 0;
        end
      end else begin
        // no strobe, array side stays quiet
        check_val("idle enables", 32'h0, {ra0_r0_enb, ra0_r1_enb, ra0_w0_enb, ra0_cfg_wr});
        check_val("idle bist ctl", 32'h0, ra0_bist_ctl);
      end
      if (pend) begin
        lat_now = lat + 1;
        if (rd_ack) begin
          check_val("ack latency", exp_lat, lat_now);
          check_val("read data", exp_dat, rd_dat);
          pend    <= 1'b0;
          rd_done <= 1'b1;
        end else if (lat_now >= ACK_LIMIT) begin
          n_err++;
          $display("%0s: read got no rd_ack within %0d cycles", test_name, ACK_LIMIT);
          pend    <= 1'b0;
          rd_done <= 1'b1;
        end else begin
          lat <= lat_now;
        end
      end else if (rd_ack) begin
        n_err++;
        $display("%0s: rd_ack seen while no read was pending", test_name);
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/sram_ctl_tb.sv
// testbench for the test chip controller: table driven commands with an array data model
`timescale 1ns/1ps
`default_nettype none

module sram_ctl_tb;

  localparam int N_ENTRY     = 23;
  localparam int MAX_WAIT    = 7;
  localparam int CYCLE_LIMIT = N_ENTRY * (2 + MAX_WAIT) + 50;

  logic         clk;
  logic         rst;
  logic         ctl_cmd_val;
  logic         ra0_cmd_val;
  logic [31:0]  cmd_adr;
  logic         cmd_we;
  logic [3:0]   cmd_sel;
  logic [31:0]  cmd_dat;
  // array model words
  logic [31:0]  ra0_r0_dat;
  logic [31:0]  ra0_r1_dat;
  logic [31:0]  ra0_bist_status;
  logic [31:0]  ra0_cfg_rdat;
  wire          rd_ack;
  wire  [31:0]  rd_dat;
  wire          ra0_cfg_wr;
  wire  [31:0]  ra0_cfg_wdat;
  wire  [31:0]  ra0_bist_ctl;
  wire          ra0_r0_enb;
  wire  [4:0]   ra0_r0_adr;
  wire          ra0_r1_enb;
  wire  [4:0]   ra0_r1_adr;
  wire          ra0_w0_enb;
  wire  [4:0]   ra0_w0_adr;
  wire  [31:0]  ra0_w0_dat;

  // stimulus table with one array per field
  logic [127:0] t_name [N_ENTRY];
  logic         t_ctl  [N_ENTRY];
  logic         t_ra   [N_ENTRY];
  logic         t_we   [N_ENTRY];
  logic [3:0]   t_sel  [N_ENTRY];
  logic [31:0]  t_adr  [N_ENTRY];
  logic [31:0]  t_dat  [N_ENTRY];
  logic [31:0]  t_r0   [N_ENTRY];
  logic [31:0]  t_r1   [N_ENTRY];
  logic [31:0]  t_bist [N_ENTRY];
  logic [31:0]  t_acfg [N_ENTRY];
  logic [31:0]  t_exp  [N_ENTRY];
  logic [31:0]  t_lat  [N_ENTRY];

  int           n_fill;
  integer       seed;
  logic [31:0]  model_cfg0;
  logic [127:0] test_name;
  logic [31:0]  exp_dat;
  logic [31:0]  exp_lat;
  wire          rd_done;
  int           err_count;
  int           chk_count;
  int           cycles;

  sram_ctl u_dut (.*);

  sram_ctl_monitor u_mon (.*);

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // append one command with its array words and its expected read word
  task automatic add_entry(input logic [127:0] name, input logic ctl, input logic ra,
                           input logic we, input logic [3:0] sel, input logic [31:0] adr,
                           input logic [31:0] dat);
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] bst;
    logic [31:0] acf;
    r0  = $random(seed);
    r1  = $random(seed);
    bst = $random(seed);
    acf = $random(seed);
    t_name[n_fill] = name;
    t_ctl[n_fill]  = ctl;
    t_ra[n_fill]   = ra;
    t_we[n_fill]   = we;
    t_sel[n_fill]  = sel;
    t_adr[n_fill]  = adr;
    t_dat[n_fill]  = dat;
    t_r0[n_fill]   = r0;
    t_r1[n_fill]   = r1;
    t_bist[n_fill] = bst;
    t_acfg[n_fill] = acf;
    t_exp[n_fill]  = 32'h0;
    t_lat[n_fill]  = 32'h0;
    if (!we) begin
      // ack comes wait+1 cycles after the strobe
      t_lat[n_fill] = model_cfg0[2:0] + 1;
      if (adr[15:12] == 4'hF) begin
        t_exp[n_fill] = bst;
      end else if (adr[15:12] == 4'hE) begin
        t_exp[n_fill] = acf;
      end else if (ctl) begin
        t_exp[n_fill] = model_cfg0;
      end else begin
        case (adr[15:14])
          2'd0:    t_exp[n_fill] = r0;
          2'd1:    t_exp[n_fill] = r1;
          2'd2:    t_exp[n_fill] = {r1[15:0], r0[15:0]};
          default: t_exp[n_fill] = {r1[31:16], r0[31:16]};
        endcase
      end
    end else if (ctl && ((adr & ~32'h0000_F000) == 32'h0)) begin
      // control write at offset 0 lands in cfg0
      model_cfg0 = dat;
    end
    n_fill++;
  endtask

  initial begin
    seed            = 32'h9fc7;
    model_cfg0      = 32'h1;
    n_fill          = 0;
    rst             = 1'b1;
    ctl_cmd_val     = 1'b0;
    ra0_cmd_val     = 1'b0;
    cmd_adr         = 32'h0;
    cmd_we          = 1'b0;
    cmd_sel         = 4'h0;
    cmd_dat         = 32'h0;
    ra0_r0_dat      = 32'h0;
    ra0_r1_dat      = 32'h0;
    ra0_bist_status = 32'h0;
    ra0_cfg_rdat    = 32'h0;
    test_name       = "reset";
    exp_dat         = 32'h0;
    exp_lat         = 32'h0;

    //        name             ctl   ra    we    sel    adr           dat
    add_entry("reset_rd_cfg0", 1'b1, 1'b0, 1'b0, 4'hF, 32'h0000_0000, 32'h0);
    add_entry("wr_cfg0_w0",    1'b1, 1'b0, 1'b1, 4'hF, 32'h0000_0000, 32'hA5A5_0000);
    add_entry("rd_cfg0_w0",    1'b1, 1'b0, 1'b0, 4'hF, 32'h0000_0000, 32'h0);
    add_entry("wr_cfg0_w3",    1'b1, 1'b0, 1'b1, 4'hF, 32'h0000_0000, 32'h1234_5673);
    add_entry("rd_cfg0_w3",    1'b1, 1'b0, 1'b0, 4'hF, 32'h0000_0000, 32'h0);
    add_entry("wr_cfg0_w7",    1'b1, 1'b0, 1'b1, 4'hF, 32'h0000_0000, 32'hC0DE_0007);
    add_entry("rd_cfg0_w7",    1'b1, 1'b0, 1'b0, 4'hF, 32'h0000_0000, 32'h0);
    add_entry("wr_cfg0_w2",    1'b1, 1'b0, 1'b1, 4'hF, 32'h0000_0000, 32'h0000_0002);
    // other control offsets leave cfg0 alone
    add_entry("ctl_wr_other",  1'b1, 1'b0, 1'b1, 4'hF, 32'h0000_0040, 32'hFFFF_FFFF);
    add_entry("rd_cfg0_kept",  1'b1, 1'b0, 1'b0, 4'hF, 32'h0000_0000, 32'h0);
    // array reads with type in 15:14, r1 row in 10:6 and r0 row in 4:0
    add_entry("ra_rd_r0",      1'b0, 1'b1, 1'b0, 4'h0, 32'h0000_0293, 32'h0);
    add_entry("ra_rd_r1",      1'b0, 1'b1, 1'b0, 4'h0, 32'h0000_4707, 32'h0);
    add_entry("ra_rd_lo",      1'b0, 1'b1, 1'b0, 4'h0, 32'h0000_8785, 32'h0);
    add_entry("ra_rd_hi",      1'b0, 1'b1, 1'b0, 4'h0, 32'h0000_C05F, 32'h0);
    // bist and array config regions
    add_entry("ctl_rd_bist",   1'b1, 1'b0, 1'b0, 4'hF, 32'h0000_F004, 32'h0);
    add_entry("ctl_rd_acfg",   1'b1, 1'b0, 1'b0, 4'hF, 32'h0000_E008, 32'h0);
    add_entry("ra_rd_bist",    1'b0, 1'b1, 1'b0, 4'hF, 32'h0000_F010, 32'h0);
    add_entry("ra_rd_acfg",    1'b0, 1'b1, 1'b0, 4'hF, 32'h0000_E000, 32'h0);
    add_entry("ra_wr_bist",    1'b0, 1'b1, 1'b1, 4'hF, 32'h0000_F000, 32'h0BAD_F00D);
    add_entry("ra_wr_acfg",    1'b0, 1'b1, 1'b1, 4'hF, 32'h0000_E004, 32'h5EED_1234);
    // plain writes with and without byte select 0
    add_entry("ra_wr_row",     1'b0, 1'b1, 1'b1, 4'h1, 32'h0000_0011, 32'hDEAD_BEEF);
    add_entry("ra_wr_nosel",   1'b0, 1'b1, 1'b1, 4'hE, 32'h0000_0011, 32'h0123_4567);
    add_entry("rd_cfg0_final", 1'b1, 1'b0, 1'b0, 4'hF, 32'h0000_0000, 32'h0);

    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    for (int i = 0; i < N_ENTRY; i++) begin
      @(negedge clk);
      test_name       = t_name[i];
      exp_dat         = t_exp[i];
      exp_lat         = t_lat[i];
      ra0_r0_dat      = t_r0[i];
      ra0_r1_dat      = t_r1[i];
      ra0_bist_status = t_bist[i];
      ra0_cfg_rdat    = t_acfg[i];
      ctl_cmd_val     = t_ctl[i];
      ra0_cmd_val     = t_ra[i];
      cmd_we          = t_we[i];
      cmd_sel         = t_sel[i];
      cmd_adr         = t_adr[i];
      cmd_dat         = t_dat[i];
      // strobe lasts one cycle
      @(negedge clk);
      ctl_cmd_val = 1'b0;
      ra0_cmd_val = 1'b0;
      cmd_we      = 1'b0;
      cmd_sel     = 4'h0;
      cmd_adr     = 32'h0;
      cmd_dat     = 32'h0;
      // the monitor flags the end of each read whether or not it was acked
      if (!t_we[i]) begin
        while (!rd_done) begin
          @(negedge clk);
        end
      end
    end

    repeat (3) @(negedge clk);
    $display("done: %0d entries, %0d checks, %0d errors, %0d assertion failures",
             N_ENTRY, chk_count, err_count, u_dut.u_checker.fail_count);
    if (err_count == 0 && u_dut.u_checker.fail_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // run limit from the table length and the longest read
  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire
